// ==== common/cpu_pkg.sv ====
/* cpu shared types and link constants */
`default_nettype none

package cpu_pkg;

	localparam int REG_COUNT = 16;
	localparam int WORD_BYTES = 4;

	localparam logic [7:0] LINK_READ_HDR = 8'h52; // 'R'
	localparam logic [7:0] LINK_WRITE_HDR = 8'h57; // 'W'

	// words 12 to 15 fall through to halt in decode
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_ADDI = 4'd5,
		OP_LUI  = 4'd6,
		OP_LW   = 4'd7,
		OP_SW   = 4'd8,
		OP_BEQ  = 4'd9,
		OP_BNE  = 4'd10,
		OP_HALT = 4'd11
	} opcode_e;

	typedef struct packed {
		opcode_e     opcode; // [31:28]
		logic [3:0]  rd; // [27:24]
		logic [3:0]  rs1; // [23:20]
		logic [3:0]  rs2; // [19:16]
		logic [15:0] unused;
	} instr_r_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [3:0]  rd;
		logic [3:0]  rs1;
		logic [3:0]  rsvd; // rs2 slot of the register view
		logic [15:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef struct packed {
		opcode_e     opcode;
		logic [3:0]  rd;
		logic [31:0] rs1_val;
		logic [31:0] rs2_val;
		logic [31:0] imm; // already extended or shifted
		logic        uses_imm;
		logic        writes_rd;
		logic        is_load;
		logic        is_store;
		logic        is_branch;
		logic        is_halt;
	} dec_op_t;

	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] alu_val;
		logic [31:0] next_pc;
		mem_req_t    mem;
	} exe_res_t;

endpackage

`default_nettype wire

// ==== core/core_decode.sv ====
/* instruction decode */
`timescale 1ns/10ps
`default_nettype none

module core_decode import cpu_pkg::*; (
	input  wire instr_u      instr,
	input  wire logic [31:0] rs1_val,
	input  wire logic [31:0] rs2_val,
	output logic [3:0]       rs1_idx,
	output logic [3:0]       rs2_idx,
	output dec_op_t          op
);

	// rs1 sits in the same bits in both views, rs2 only exists in the register view
	assign rs1_idx = instr.i.rs1;
	assign rs2_idx = instr.r.rs2;

	always_comb begin
		op = '0;
		op.opcode = instr.r.opcode;
		op.rd = instr.r.rd;
		op.rs1_val = rs1_val;
		op.rs2_val = rs2_val;
		op.imm = {{16{instr.i.imm[15]}}, instr.i.imm}; // sign extend
		case (instr.r.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
				op.writes_rd = 1'b1;
			end
			OP_ADDI: begin
				op.uses_imm = 1'b1;
				op.writes_rd = 1'b1;
			end
			OP_LUI: begin
				op.imm = {instr.i.imm, 16'h0000}; // upper half
				op.uses_imm = 1'b1;
				op.writes_rd = 1'b1;
			end
			OP_LW: begin
				op.uses_imm = 1'b1;
				op.writes_rd = 1'b1;
				op.is_load = 1'b1;
			end
			OP_SW: begin
				op.uses_imm = 1'b1;
				op.is_store = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				op.uses_imm = 1'b1;
				op.is_branch = 1'b1;
			end
			default: begin
				op.opcode = OP_HALT; // 11 and the unused codes above it
				op.is_halt = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== core/core_execute.sv ====
/* alu and next pc */
`timescale 1ns/10ps
`default_nettype none

module core_execute import cpu_pkg::*; (
	input  wire dec_op_t     op,
	input  wire logic [31:0] pc,
	output exe_res_t         res
);

	logic [31:0] operand_b;
	logic [31:0] sum;
	logic        taken;

	assign operand_b = op.uses_imm ? op.imm : op.rs2_val;
	assign sum = op.rs1_val + operand_b; // add, addi and lw/sw address

	always_comb begin
		res = '0;
		taken = 1'b0;
		case (op.opcode)
			OP_ADD, OP_ADDI, OP_LW, OP_SW: begin
				res.alu_val = sum;
			end
			OP_SUB: begin
				res.alu_val = op.rs1_val - op.rs2_val;
			end
			OP_AND: begin
				res.alu_val = op.rs1_val & op.rs2_val;
			end
			OP_OR: begin
				res.alu_val = op.rs1_val | op.rs2_val;
			end
			OP_XOR: begin
				res.alu_val = op.rs1_val ^ op.rs2_val;
			end
			OP_LUI: begin
				res.alu_val = op.imm;
			end
			OP_BEQ: begin
				taken = (op.rs1_val == op.rs2_val);
			end
			OP_BNE: begin
				taken = (op.rs1_val != op.rs2_val);
			end
			default: begin
				res.alu_val = '0;
			end
		endcase

		// branch offset counts words
		if (op.is_branch && taken) begin
			res.next_pc = pc + (op.imm << 2);
		end else begin
			res.next_pc = pc + 32'(WORD_BYTES);
		end

		res.mem.write = op.is_store;
		res.mem.addr = sum;
		res.mem.wdata = op.rs2_val; // store data
	end

endmodule

`default_nettype wire

// ==== core/core_result.sv ====
/* register file and write back */
`timescale 1ns/10ps
`default_nettype none

module core_result import cpu_pkg::*; (
	input  wire              CLK,
	input  wire              rst,
	input  wire              wr_en,
	input  wire dec_op_t     op,
	input  wire logic [31:0] alu_val,
	input  wire logic [31:0] load_val,
	input  wire logic [3:0]  rs1_idx,
	input  wire logic [3:0]  rs2_idx,
	output logic [31:0]      rs1_val,
	output logic [31:0]      rs2_val
);

	logic [31:0] regs [REG_COUNT];
	logic [31:0] wb_val;

	assign wb_val = op.is_load ? load_val : alu_val;

	always_ff @(posedge CLK or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && op.writes_rd && (op.rd != 4'd0)) begin
			regs[op.rd] <= wb_val; // r0 writes dropped
		end
	end

	assign rs1_val = (rs1_idx == 4'd0) ? '0 : regs[rs1_idx];
	assign rs2_val = (rs2_idx == 4'd0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

// ==== core/cpu_core.sv ====
/* multi-cycle cpu core */
`timescale 1ns/10ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
	input  wire              CLK,
	input  wire              rst,
	output logic             mem_req,
	output mem_req_t         req,
	input  wire              mem_done,
	input  wire logic [31:0] rdata,
	output logic             halted,
	output logic [31:0]      halt_pc
);

	typedef enum logic [2:0] {
		S_FETCH,
		S_FETCH_WAIT,
		S_DECODE,
		S_EXECUTE,
		S_MEM,
		S_MEM_WAIT,
		S_RESULT,
		S_HALTED
	} state_e;

	state_e      state;
	logic [31:0] pc;
	instr_u      instr_q;
	dec_op_t     dec_op;
	dec_op_t     dec_q;
	exe_res_t    exe_res;
	exe_res_t    exe_q;
	logic [3:0]  rs1_idx;
	logic [3:0]  rs2_idx;
	logic [31:0] rs1_val;
	logic [31:0] rs2_val;

	core_decode decode (
		.instr   (instr_q),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.rs1_idx (rs1_idx),
		.rs2_idx (rs2_idx),
		.op      (dec_op)
	);

	core_execute execute (
		.op  (dec_q),
		.pc  (pc),
		.res (exe_res)
	);

	// rdata still holds the loaded word in the result cycle
	core_result result (
		.CLK      (CLK),
		.rst      (rst),
		.wr_en    (state == S_RESULT),
		.op       (dec_q),
		.alu_val  (exe_q.alu_val),
		.load_val (rdata),
		.rs1_idx  (rs1_idx),
		.rs2_idx  (rs2_idx),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val)
	);

	always_ff @(posedge CLK or posedge rst) begin
		if (rst) begin
			state <= S_FETCH;
			pc <= '0;
		end else begin
			case (state)
				S_FETCH: state <= S_FETCH_WAIT;
				S_FETCH_WAIT: if (mem_done) state <= S_DECODE;
				S_DECODE: state <= S_EXECUTE;
				S_EXECUTE: state <= (dec_q.is_load || dec_q.is_store) ? S_MEM : S_RESULT;
				S_MEM: state <= S_MEM_WAIT;
				S_MEM_WAIT: if (mem_done) state <= S_RESULT;
				S_RESULT: begin
					if (dec_q.is_halt) begin
						state <= S_HALTED; // pc stays on the halt
					end else begin
						pc <= exe_q.next_pc;
						state <= S_FETCH;
					end
				end
				default: state <= S_HALTED;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == S_FETCH_WAIT && mem_done) instr_q <= rdata;
		if (state == S_DECODE) dec_q <= dec_op;
		if (state == S_EXECUTE) exe_q <= exe_res;
	end

	assign mem_req = !rst && ((state == S_FETCH) || (state == S_MEM));

	always_comb begin
		if (state == S_FETCH || state == S_FETCH_WAIT) begin
			req.write = 1'b0;
			req.addr = pc;
			req.wdata = '0;
		end else begin
			req = exe_q.mem;
		end
	end

	assign halted = (state == S_HALTED);
	assign halt_pc = pc;

endmodule

`default_nettype wire

// ==== logic/memory_controller.sv ====
/* memory requests over the byte link */
`timescale 1ns/10ps
`default_nettype none

module memory_controller import cpu_pkg::*; (
	input  wire              CLK,
	input  wire              rst,
	input  wire              mem_req,
	input  wire mem_req_t    req,
	output logic             mem_done,
	output logic [31:0]      rdata,
	input  wire              rx_valid,
	input  wire logic [7:0]  rx_byte,
	input  wire              tx_busy,
	output logic             tx_valid,
	output logic [7:0]       tx_byte
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_SEND,
		M_RECV,
		M_DONE
	} mstate_e;

	mstate_e    state;
	mem_req_t   req_q;
	logic [3:0] byte_idx;
	logic [3:0] last_idx;
	logic [1:0] rx_cnt;
	logic [(1 + 2 * WORD_BYTES) * 8 - 1:0] msg;

	// header in the low byte, then address and data, lsb first
	assign msg = {req_q.wdata, req_q.addr, req_q.write ? LINK_WRITE_HDR : LINK_READ_HDR};
	assign last_idx = req_q.write ? 4'(2 * WORD_BYTES) : 4'(WORD_BYTES);

	assign tx_valid = (state == M_SEND) && !tx_busy; // held byte waits out busy
	assign tx_byte = msg[{byte_idx, 3'b000} +: 8];
	assign mem_done = (state == M_DONE);

	always_ff @(posedge CLK or posedge rst) begin
		if (rst) begin
			state <= M_IDLE;
			byte_idx <= '0;
			rx_cnt <= '0;
		end else begin
			case (state)
				M_IDLE: begin
					if (mem_req) begin
						byte_idx <= '0;
						state <= M_SEND;
					end
				end
				M_SEND: begin
					if (!tx_busy) begin
						byte_idx <= byte_idx + 4'd1;
						if (byte_idx == last_idx) begin
							rx_cnt <= '0;
							state <= req_q.write ? M_DONE : M_RECV;
						end
					end
				end
				M_RECV: begin
					if (rx_valid) begin
						rx_cnt <= rx_cnt + 2'd1;
						if (rx_cnt == 2'(WORD_BYTES - 1)) state <= M_DONE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == M_IDLE && mem_req) req_q <= req;
		if (state == M_RECV && rx_valid) begin
			rdata <= {rx_byte, rdata[31:8]}; // first byte ends up lowest
		end
	end

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
/* cpu subsystem top */
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input  wire             CLK,
	input  wire             button,
	input  wire             rx_valid,
	input  wire logic [7:0] rx_byte,
	input  wire             tx_busy,
	output logic            tx_valid,
	output logic [7:0]      tx_byte,
	output logic            halted,
	output logic [31:0]     halt_pc
);

	logic        rst_meta;
	logic        rst;
	logic        mem_req;
	mem_req_t    req;
	logic        mem_done;
	logic [31:0] rdata;

	// asserts with the button, releases two edges after it
	always_ff @(posedge CLK or posedge button) begin
		if (button) begin
			rst_meta <= 1'b1;
			rst <= 1'b1;
		end else begin
			rst_meta <= 1'b0;
			rst <= rst_meta;
		end
	end

	memory_controller mem_ctrl (
		.CLK      (CLK),
		.rst      (rst),
		.mem_req  (mem_req),
		.req      (req),
		.mem_done (mem_done),
		.rdata    (rdata),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte),
		.tx_busy  (tx_busy),
		.tx_valid (tx_valid),
		.tx_byte  (tx_byte)
	);

	cpu_core core (
		.CLK      (CLK),
		.rst      (rst),
		.mem_req  (mem_req),
		.req      (req),
		.mem_done (mem_done),
		.rdata    (rdata),
		.halted   (halted),
		.halt_pc  (halt_pc)
	);

endmodule

`default_nettype wire

// ==== verif/tb_cpu.sv ====
/* cpu subsystem testbench */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	logic        CLK;
	logic        button;
	logic        rx_valid;
	logic [7:0]  rx_byte;
	logic        tx_busy;
	logic        tx_valid;
	logic [7:0]  tx_byte;
	logic        halted;
	logic [31:0] halt_pc;

	// stim[0] memory words, stim[1] stores, stim[2] halt pc, then image and store pairs
	logic [31:0] stim [64];
	logic [31:0] host_mem [64];
	logic [31:0] model_mem [64]; // memory as the reference walk leaves it
	mem_req_t    exp_reads [$];
	integer      seed = 42;
	int          store_idx = 0;
	int          tx_count = 0;
	logic [7:0]  msg [9];
	int          msg_len = 0;
	logic [31:0] reply_word = '0;
	int          reply_left = 0;
	int          reply_gap = 0;
	bit          stim_loaded;

	cpu_top DUT (
		.CLK      (CLK),
		.button   (button),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte),
		.tx_busy  (tx_busy),
		.tx_valid (tx_valid),
		.tx_byte  (tx_byte),
		.halted   (halted),
		.halt_pc  (halt_pc)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_req(input string name, input mem_req_t got, input mem_req_t want);
		if (got !== want) begin
			abort_run($sformatf("ERR %0t %s got w=%b a=%h d=%h expected w=%b a=%h d=%h", $time,
				name, got.write, got.addr, got.wdata, want.write, want.addr, want.wdata));
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, want));
		end
	endtask

	task automatic check_pc(input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			abort_run($sformatf("ERR %0t halt_pc got %h expected %h", $time, got, want));
		end
	endtask

	// reference walk of the program that queues every read the core must issue
	task automatic walk_program();
		logic [31:0] regs [16];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] ea;
		logic [31:0] val;
		mem_req_t    r;
		bit          done;
		int          step;
		foreach (regs[i]) regs[i] = '0;
		pc = '0;
		done = 1'b0;
		for (step = 0; step < 4000 && !done; step++) begin
			r = '0;
			r.addr = pc;
			exp_reads.push_back(r);
			w = model_mem[pc[7:2]];
			a = regs[w[23:20]];
			b = regs[w[19:16]];
			sx = {{16{w[15]}}, w[15:0]};
			ea = a + sx;
			val = '0;
			case (w[31:28])
				OP_ADD: val = a + b;
				OP_SUB: val = a - b;
				OP_AND: val = a & b;
				OP_OR: val = a | b;
				OP_XOR: val = a ^ b;
				OP_ADDI: val = ea;
				OP_LUI: val = {w[15:0], 16'h0000};
				OP_LW: begin
					r.addr = ea;
					exp_reads.push_back(r);
					val = model_mem[ea[7:2]];
				end
				OP_SW: model_mem[ea[7:2]] = b;
				default: val = '0;
			endcase
			if (w[31:28] <= OP_LW && w[27:24] != 4'd0) regs[w[27:24]] = val;
			if ((w[31:28] == OP_BEQ && a == b) || (w[31:28] == OP_BNE && a != b)) begin
				pc = pc + (sx << 2);
			end else if (w[31:28] >= OP_HALT) begin
				done = 1'b1;
			end else begin
				pc = pc + 32'd4;
			end
		end
	endtask

	// host side of the link
	always @(posedge CLK) begin
		mem_req_t    got;
		mem_req_t    want;
		logic [31:0] addr;
		logic [31:0] data;
		int          base;
		tx_busy <= (($random(seed) & 3) == 0);
		rx_valid <= 1'b0;
		if (reply_left != 0) begin
			if (reply_gap != 0) begin
				reply_gap <= reply_gap - 1;
			end else begin
				rx_valid <= 1'b1;
				rx_byte <= reply_word[7:0]; // lsb first
				reply_word <= reply_word >> 8;
				reply_left <= reply_left - 1;
				reply_gap <= $random(seed) & 3;
			end
		end
		if (tx_valid === 1'b1) begin
			tx_count++;
			if (tx_busy !== 1'b0) abort_run("a byte was sent while tx_busy was high");
			if (reply_left != 0) abort_run("a byte was sent while a read reply was pending");
			if (msg_len == 0 && tx_byte != LINK_READ_HDR && tx_byte != LINK_WRITE_HDR) begin
				abort_run($sformatf("protocol failure, bad header byte %h", tx_byte));
			end
			msg[msg_len] = tx_byte;
			msg_len++;
			addr = {msg[4], msg[3], msg[2], msg[1]};
			data = {msg[8], msg[7], msg[6], msg[5]};
			got = '0;
			if (msg_len == 5 && msg[0] == LINK_READ_HDR) begin
				if (addr[31:8] != '0 || addr[1:0] != 2'b00) abort_run("read outside host memory");
				if (exp_reads.size() == 0) abort_run("read message after the program ended");
				got.addr = addr;
				check_req("tx_byte read message", got, exp_reads.pop_front());
				reply_word <= host_mem[addr[7:2]];
				reply_left <= 4;
				reply_gap <= $random(seed) & 3;
				msg_len = 0;
			end else if (msg_len == 9) begin
				if (addr[31:8] != '0 || addr[1:0] != 2'b00) abort_run("write outside host memory");
				if (store_idx >= stim[1]) abort_run("more stores than the stimulus expects");
				base = 3 + stim[0] + 2 * store_idx;
				got.write = 1'b1;
				got.addr = addr;
				got.wdata = data;
				want.write = 1'b1;
				want.addr = stim[base];
				want.wdata = stim[base + 1];
				check_req("tx_byte write message", got, want);
				host_mem[addr[7:2]] = data;
				store_idx++;
				msg_len = 0;
			end
		end
	end

	initial begin
		int halt_count;
		button <= 1'b1;
		rx_valid <= 1'b0;
		rx_byte <= 8'h00;
		tx_busy <= 1'b0;
		$readmemh("verif/cpu_stim.txt", stim);
		foreach (host_mem[i]) host_mem[i] = 32'hc0de_0000 | (i << 2); // tag with byte address
		for (int i = 0; i < stim[0]; i++) host_mem[i] = stim[3 + i];
		model_mem = host_mem;
		walk_program();
		stim_loaded = 1'b1;
		repeat (16) @(posedge CLK);
		button <= 1'b0;
		while (halted !== 1'b1) @(negedge CLK);
		check_pc(halt_pc, stim[2]);
		check_word("store count", store_idx, stim[1]);
		check_word("reads left", exp_reads.size(), 32'd0);
		halt_count = tx_count;
		repeat (100) @(negedge CLK);
		if (tx_count == halt_count) begin
			$display("Done: no errors");
			$finish;
		end else begin
			abort_run("tx_valid seen after halted rose");
		end
	end

	// watchdog
	initial begin
		int limit;
		wait (stim_loaded);
		limit = stim[0] * 400 + 2000;
		repeat (limit) @(posedge CLK);
		abort_run($sformatf("timeout after %0d cycles, the program never halted", limit));
	end

endmodule

`default_nettype wire

// ==== verif/cpu_stim.txt ====
// header: memory word count, expected store count, expected halt pc
// then the memory image from address 0, then one address and data pair per store
0000001A 00000007 0000005C
// program, words 0 to 23
61001234 51105678 72000060 73000064
04230000 80040080 15230000 80050084
26120000 80060088 37130000 8007008C
48120000 80080090 50100005 80000094
59000003 5990FFFF A090FFFF 90000002
800100A0 5B90FFF0 800B0098 B0000000
// data at 0x60 and 0x64
89ABCDEF 0F1E2D3C
// expected stores in order
00000080 98C9FB2B 00000084 7A8DA0B3 00000088 00204468
0000008C 1F3E7F7C 00000090 9B9F9B97 00000094 00000000
00000098 FFFFFFF0

// ==== all.f ====
common/cpu_pkg.sv
core/core_decode.sv
core/core_execute.sv
core/core_result.sv
core/cpu_core.sv
logic/memory_controller.sv
logic/cpu_top.sv
verif/tb_cpu.sv
